/* project.f */
+incdir+hdl
hdl/app_pkg.sv
hdl/rx_qpn_tagger.sv
hdl/tx_qpn_monitor.sv
hdl/pkt_stats.sv
hdl/app_reg_file.sv
hdl/pkt_app_top.sv
sim/tb_clkgen.sv
sim/pkt_app_chk.sv
sim/tb_pkt_app.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_pkt_app
FILELIST  = project.f
OBJ_DIR   = obj_dir
SIM_BIN   = $(OBJ_DIR)/V$(TOP)
SIM_ARGS  = +verilator+error+limit+1000
LOG       = sim.log
SOURCES   = $(wildcard hdl/*.sv hdl/*.svh sim/*.sv)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: $(SIM_BIN)
	$(SIM_BIN) $(SIM_ARGS) | tee $(LOG)
	grep -qx "TEST OK" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* sim/tb_pkt_app.sv */
// table-driven testbench that checks rx, tx and register steps of the packet app against a model
`timescale 1ns/1ps
`default_nettype none

`include "app_defs.svh"

module tb_pkt_app import app_pkg::*; ();

    typedef enum logic [1:0] {
        STEP_RX,
        STEP_TX,
        STEP_WR,
        STEP_RD
    } step_kind_t;

    typedef struct packed {
        step_kind_t kind;
        logic [7:0] beats;
        qpn_t       qpn;
        logic [4:0] opcode;
        logic [7:0] stall;
        reg_addr_t  addr;
        reg_data_t  data;
        reg_data_t  exp_val;
    } step_t;

    logic      clk;
    logic      rst;
    data_t     s_rx_tdata;
    keep_t     s_rx_tkeep;
    logic      s_rx_tvalid;
    logic      s_rx_tready;
    logic      s_rx_tlast;
    rx_user_t  s_rx_tuser;
    data_t     m_rx_tdata;
    keep_t     m_rx_tkeep;
    logic      m_rx_tvalid;
    logic      m_rx_tready;
    logic      m_rx_tlast;
    rx_user_t  m_rx_tuser;
    data_t     s_tx_tdata;
    keep_t     s_tx_tkeep;
    logic      s_tx_tvalid;
    logic      s_tx_tready;
    logic      s_tx_tlast;
    tx_user_t  s_tx_tuser;
    data_t     m_tx_tdata;
    keep_t     m_tx_tkeep;
    logic      m_tx_tvalid;
    logic      m_tx_tready;
    logic      m_tx_tlast;
    tx_user_t  m_tx_tuser;
    logic      reg_wr_en;
    reg_addr_t reg_wr_addr;
    reg_data_t reg_wr_data;
    logic      reg_wr_ack;
    logic      reg_rd_en;
    reg_addr_t reg_rd_addr;
    reg_data_t reg_rd_data;
    logic      reg_rd_ack;

    step_t       steps[$];
    qpn_t        mdl_dest_qpn;
    qpn_t        mdl_local_qpn;
    cnt_t        mdl_rx_pkts;
    cnt_t        mdl_tx_pkts;
    logic        mdl_clear;
    logic [31:0] lcg_state;
    int          step_errs;
    int          pass_cnt = 0;
    int          fail_cnt = 0;
    int          cycle_count = 0;
    int          cycle_limit = 0;

    tb_clkgen #(.PERIOD_NS(20)) u_clkgen (.clk(clk));

    pkt_app_top dut (.*);

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic step_t blank_step(input step_kind_t kind);
        step_t st;
        st = '0;
        st.kind = kind;
        return st;
    endfunction

    // random payload with the header fields on the first beat
    function automatic data_t make_beat(input step_t st, input logic first);
        data_t d;
        int    i;
        for (i = 0; i < `APP_DATA_W / 32; i++) begin
            d[i*32 +: 32] = lcg_next();
        end
        if (first && st.kind == STEP_RX) begin
            d[`APP_DEST_QPN_BIT +: `APP_QPN_W] = st.qpn;
        end
        if (first && st.kind == STEP_TX) begin
            d[`APP_OPCODE_BIT +: `APP_OPCODE_W] = st.opcode;
            d[`APP_LOCAL_QPN_BIT +: `APP_QPN_W] = st.qpn;
        end
        return d;
    endfunction

    task automatic add_packet(input step_kind_t kind, input int beats, input qpn_t qpn,
                              input logic [4:0] opcode, input logic [7:0] stall);
        step_t st;
        st = blank_step(kind);
        st.beats = 8'(beats);
        st.qpn = qpn;
        st.opcode = opcode;
        st.stall = stall;
        if (kind == STEP_RX) begin
            mdl_dest_qpn = qpn;
        end else if (opcode == `APP_OPCODE_FIRST) begin
            mdl_local_qpn = qpn;
        end
        // counters stay at zero while clear is set
        if (!mdl_clear && kind == STEP_RX) begin
            mdl_rx_pkts++;
        end
        if (!mdl_clear && kind == STEP_TX) begin
            mdl_tx_pkts++;
        end
        steps.push_back(st);
    endtask

    task automatic add_write(input logic [7:0] off, input reg_data_t data);
        step_t st;
        st = blank_step(STEP_WR);
        st.addr = {8'h00, off};
        st.data = data;
        if (off == `APP_REG_CLEAR) begin
            mdl_clear = data[0];
        end
        if (mdl_clear) begin
            mdl_rx_pkts = '0;
            mdl_tx_pkts = '0;
        end
        steps.push_back(st);
    endtask

    task automatic add_read(input logic [7:0] off);
        step_t st;
        st = blank_step(STEP_RD);
        st.addr = {8'h00, off};
        case (off)
            `APP_REG_DEST_QPN:  st.exp_val = reg_data_t'(mdl_dest_qpn);
            `APP_REG_RX_PKTS:   st.exp_val = mdl_rx_pkts;
            `APP_REG_TX_PKTS:   st.exp_val = mdl_tx_pkts;
            `APP_REG_VERSION:   st.exp_val = `APP_VERSION;
            `APP_REG_CLEAR:     st.exp_val = reg_data_t'(mdl_clear);
            `APP_REG_LOCAL_QPN: st.exp_val = reg_data_t'(mdl_local_qpn);
            default:            st.exp_val = '0;
        endcase
        steps.push_back(st);
    endtask

    task automatic log_error(input string msg);
        $display("FAIL at %0d ns: %s", $time, msg);
        step_errs++;
    endtask

    // one beat offered per cycle and held until the sink takes it
    task automatic run_packet(input step_t st);
        data_t    beat_data;
        keep_t    beat_keep;
        rx_user_t beat_user;
        logic     rdy;
        logic     last;
        int       beat;
        int       cyc;
        beat = 0;
        cyc = 0;
        beat_data = make_beat(st, 1'b1);
        beat_user = {lcg_next(), lcg_next(), lcg_next()};
        while (beat < int'(st.beats)) begin
            rdy = (cyc >= 8) || !st.stall[cyc[2:0]];
            last = (beat == int'(st.beats) - 1);
            beat_keep = last ? 64'h0000_0fff_ffff_ffff : 64'hffff_ffff_ffff_ffff;
            if (st.kind == STEP_RX) begin
                s_rx_tdata = beat_data;
                s_rx_tkeep = beat_keep;
                s_rx_tuser = beat_user;
                s_rx_tlast = last;
                s_rx_tvalid = 1'b1;
                m_rx_tready = rdy;
            end else begin
                s_tx_tdata = beat_data;
                s_tx_tkeep = beat_keep;
                s_tx_tuser = beat_user[`APP_TX_USER_W-1:0];
                s_tx_tlast = last;
                s_tx_tvalid = 1'b1;
                m_tx_tready = rdy;
            end
            #1;
            if (st.kind == STEP_RX) begin
                if (m_rx_tdata !== beat_data || m_rx_tkeep !== beat_keep
                        || m_rx_tlast !== last || m_rx_tvalid !== 1'b1) begin
                    log_error($sformatf("rx beat %0d differs from its input", beat));
                end
                if (m_rx_tuser !== {st.qpn, beat_user[`APP_RX_USER_W-`APP_QPN_W-1:0]}) begin
                    log_error($sformatf("rx beat %0d tuser %h, qpn should be %h",
                                        beat, m_rx_tuser, st.qpn));
                end
                if (s_rx_tready !== rdy) begin
                    log_error($sformatf("s_rx_tready %b, expected %b", s_rx_tready, rdy));
                end
            end else begin
                if (m_tx_tdata !== beat_data || m_tx_tkeep !== beat_keep
                        || m_tx_tlast !== last || m_tx_tvalid !== 1'b1
                        || m_tx_tuser !== beat_user[`APP_TX_USER_W-1:0]) begin
                    log_error($sformatf("tx beat %0d differs from its input", beat));
                end
                if (s_tx_tready !== rdy) begin
                    log_error($sformatf("s_tx_tready %b, expected %b", s_tx_tready, rdy));
                end
            end
            @(posedge clk);
            #2;
            if (rdy) begin
                beat++;
                beat_data = make_beat(st, 1'b0);
                beat_user = {lcg_next(), lcg_next(), lcg_next()};
            end
            cyc++;
        end
        s_rx_tvalid = 1'b0;
        s_rx_tlast = 1'b0;
        m_rx_tready = 1'b1;
        s_tx_tvalid = 1'b0;
        s_tx_tlast = 1'b0;
        m_tx_tready = 1'b1;
    endtask

    task automatic run_reg(input step_t st);
        if (st.kind == STEP_WR) begin
            reg_wr_en = 1'b1;
            reg_wr_addr = st.addr;
            reg_wr_data = st.data;
        end else begin
            reg_rd_en = 1'b1;
            reg_rd_addr = st.addr;
        end
        @(posedge clk);
        #2;
        reg_wr_en = 1'b0;
        reg_rd_en = 1'b0;
        if (st.kind == STEP_WR && reg_wr_ack !== 1'b1) begin
            log_error("reg_wr_ack not high one cycle after the enable");
        end
        if (st.kind == STEP_RD && reg_rd_ack !== 1'b1) begin
            log_error("reg_rd_ack not high one cycle after the enable");
        end
        if (st.kind == STEP_RD && reg_rd_data !== st.exp_val) begin
            log_error($sformatf("read of %h returned %h, expected %h",
                                st.addr, reg_rd_data, st.exp_val));
        end
        @(posedge clk);
        #2;
        if (reg_wr_ack !== 1'b0 || reg_rd_ack !== 1'b0) begin
            log_error("register ack held for more than one cycle");
        end
    endtask

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_limit > 0 && cycle_count > cycle_limit) begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("TEST FAILED");
            $finish;
        end
    end

    initial begin
        int         i;
        int         total;
        step_t      st;
        step_kind_t kind;
        lcg_state = 32'hf74d4a40;
        rst = 1'b1;
        s_rx_tdata = '0;
        s_rx_tkeep = '0;
        s_rx_tvalid = 1'b0;
        s_rx_tlast = 1'b0;
        s_rx_tuser = '0;
        m_rx_tready = 1'b1;
        s_tx_tdata = '0;
        s_tx_tkeep = '0;
        s_tx_tvalid = 1'b0;
        s_tx_tlast = 1'b0;
        s_tx_tuser = '0;
        m_tx_tready = 1'b1;
        reg_wr_en = 1'b0;
        reg_wr_addr = '0;
        reg_wr_data = '0;
        reg_rd_en = 1'b0;
        reg_rd_addr = '0;
        mdl_dest_qpn = '0;
        mdl_local_qpn = '0;
        mdl_rx_pkts = '0;
        mdl_tx_pkts = '0;
        mdl_clear = 1'b0;

        // step table built alongside the reference model
        add_packet(STEP_RX, 3, 24'h0a1b2c, 5'd0, 8'h00);
        add_read(`APP_REG_DEST_QPN);
        add_packet(STEP_RX, 4, 24'h123456, 5'd0, 8'b0001_0110);
        add_read(`APP_REG_RX_PKTS);
        add_read(`APP_REG_DEST_QPN);
        add_packet(STEP_TX, 2, 24'h00c0de, `APP_OPCODE_FIRST, 8'h00);
        add_read(`APP_REG_LOCAL_QPN);
        add_packet(STEP_TX, 3, 24'hbad001, 5'b01010, 8'b0000_0101);
        add_read(`APP_REG_LOCAL_QPN);
        add_read(`APP_REG_TX_PKTS);
        add_packet(STEP_RX, 1, 24'hfedcba, 5'd0, 8'h01);
        add_read(`APP_REG_RX_PKTS);
        add_read(`APP_REG_VERSION);
        add_read(8'h70);
        add_write(`APP_REG_CLEAR, 32'd1);
        add_packet(STEP_RX, 2, 24'h0c1ea2, 5'd0, 8'h00);
        add_read(`APP_REG_RX_PKTS);
        add_read(`APP_REG_TX_PKTS);
        add_read(`APP_REG_CLEAR);
        add_write(`APP_REG_CLEAR, 32'd0);
        add_packet(STEP_TX, 1, 24'h5a5a5a, `APP_OPCODE_FIRST, 8'h00);
        add_packet(STEP_RX, 2, 24'h777777, 5'd0, 8'b0000_0010);
        add_read(`APP_REG_RX_PKTS);
        add_read(`APP_REG_TX_PKTS);
        add_write(`APP_REG_DEST_QPN, 32'hffff_ffff);
        add_read(`APP_REG_DEST_QPN);
        add_read(`APP_REG_LOCAL_QPN);

        // beats plus stall cycles and two cycles per register access
        total = 3;
        for (i = 0; i < steps.size(); i++) begin
            if (steps[i].kind == STEP_RX || steps[i].kind == STEP_TX) begin
                total += int'(steps[i].beats) + $countones(steps[i].stall);
            end else begin
                total += 2;
            end
        end
        cycle_limit = 2 * total + 100;

        repeat (3) @(posedge clk);
        #2;
        rst = 1'b0;

        for (i = 0; i < steps.size(); i++) begin
            st = steps[i];
            kind = st.kind;
            step_errs = 0;
            if (kind == STEP_RX || kind == STEP_TX) begin
                run_packet(st);
            end else begin
                run_reg(st);
            end
            if (step_errs == 0) begin
                pass_cnt++;
            end else begin
                fail_cnt++;
            end
            $display("step %0d %s: %s", i, kind.name(), (step_errs == 0) ? "passed" : "failed");
        end

        if (dut.chk.err_count != 0) begin
            $display("bound checker reported %0d assertion failures", dut.chk.err_count);
            fail_cnt++;
        end
        $display("steps passed %0d, failed %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sim/pkt_app_chk.sv */
// packet app checker: concurrent assertions on the register acks and rx pass-through
`timescale 1ns/1ps
`default_nettype none

`include "app_defs.svh"

module pkt_app_chk import app_pkg::*; (
    input logic     clk,
    input logic     rst,
    input logic     reg_wr_en,
    input logic     reg_wr_ack,
    input logic     reg_rd_en,
    input logic     reg_rd_ack,
    input logic     s_rx_tready,
    input logic     m_rx_tready,
    input rx_user_t s_rx_tuser,
    input rx_user_t m_rx_tuser
);

    localparam int LOW_W = `APP_RX_USER_W - `APP_QPN_W;

    int err_count = 0;

    // acks one cycle after the enable
    wr_ack_next: assert property (@(posedge clk) disable iff (rst) reg_wr_en |=> reg_wr_ack)
    else begin
        $error("reg_wr_ack missing in the cycle after reg_wr_en");
        err_count++;
    end

    rd_ack_next: assert property (@(posedge clk) disable iff (rst) reg_rd_en |=> reg_rd_ack)
    else begin
        $error("reg_rd_ack missing in the cycle after reg_rd_en");
        err_count++;
    end

    // ready passes straight back
    rx_ready_thru: assert property (@(posedge clk) s_rx_tready == m_rx_tready)
    else begin
        $error("s_rx_tready differs from m_rx_tready");
        err_count++;
    end

    // only the qpn field of tuser is replaced
    rx_user_low: assert property (@(posedge clk) m_rx_tuser[LOW_W-1:0] == s_rx_tuser[LOW_W-1:0])
    else begin
        $error("low rx tuser bits changed across the block");
        err_count++;
    end

    acks_after_rst: assert property (@(posedge clk) rst |=> !reg_wr_ack && !reg_rd_ack)
    else begin
        $error("register ack high in the cycle after reset");
        err_count++;
    end

endmodule

bind pkt_app_top pkt_app_chk chk (
    .clk         (clk),
    .rst         (rst),
    .reg_wr_en   (reg_wr_en),
    .reg_wr_ack  (reg_wr_ack),
    .reg_rd_en   (reg_rd_en),
    .reg_rd_ack  (reg_rd_ack),
    .s_rx_tready (s_rx_tready),
    .m_rx_tready (m_rx_tready),
    .s_rx_tuser  (s_rx_tuser),
    .m_rx_tuser  (m_rx_tuser)
);

`default_nettype wire

/* sim/tb_clkgen.sv */
// testbench clock generator: free-running clock with a fixed period
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen #(
    parameter int PERIOD_NS = 20
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    // half period high, half period low
    always begin
        #(PERIOD_NS / 2);
        clk = ~clk;
    end

endmodule

`default_nettype wire

/* hdl/pkt_app_top.sv */
// packet app top: rx/tx stream watchers, packet statistics and register file
`timescale 1ns/1ps
`default_nettype none

module pkt_app_top import app_pkg::*; (
    input  logic      clk,
    input  logic      rst,

    // rx stream
    input  data_t     s_rx_tdata,
    input  keep_t     s_rx_tkeep,
    input  logic      s_rx_tvalid,
    output logic      s_rx_tready,
    input  logic      s_rx_tlast,
    input  rx_user_t  s_rx_tuser,
    output data_t     m_rx_tdata,
    output keep_t     m_rx_tkeep,
    output logic      m_rx_tvalid,
    input  logic      m_rx_tready,
    output logic      m_rx_tlast,
    output rx_user_t  m_rx_tuser,

    // tx stream
    input  data_t     s_tx_tdata,
    input  keep_t     s_tx_tkeep,
    input  logic      s_tx_tvalid,
    output logic      s_tx_tready,
    input  logic      s_tx_tlast,
    input  tx_user_t  s_tx_tuser,
    output data_t     m_tx_tdata,
    output keep_t     m_tx_tkeep,
    output logic      m_tx_tvalid,
    input  logic      m_tx_tready,
    output logic      m_tx_tlast,
    output tx_user_t  m_tx_tuser,

    // register port
    input  logic      reg_wr_en,
    input  reg_addr_t reg_wr_addr,
    input  reg_data_t reg_wr_data,
    output logic      reg_wr_ack,
    input  logic      reg_rd_en,
    input  reg_addr_t reg_rd_addr,
    output reg_data_t reg_rd_data,
    output logic      reg_rd_ack
);

    qpn_t dest_qpn;
    qpn_t local_qpn;
    cnt_t rx_pkts;
    cnt_t tx_pkts;
    logic rx_pkt_done;
    logic tx_pkt_done;
    logic clear;

    rx_qpn_tagger u_rx_qpn_tagger (
        .clk         (clk),
        .rst         (rst),
        .s_rx_tdata  (s_rx_tdata),
        .s_rx_tkeep  (s_rx_tkeep),
        .s_rx_tvalid (s_rx_tvalid),
        .s_rx_tready (s_rx_tready),
        .s_rx_tlast  (s_rx_tlast),
        .s_rx_tuser  (s_rx_tuser),
        .m_rx_tdata  (m_rx_tdata),
        .m_rx_tkeep  (m_rx_tkeep),
        .m_rx_tvalid (m_rx_tvalid),
        .m_rx_tready (m_rx_tready),
        .m_rx_tlast  (m_rx_tlast),
        .m_rx_tuser  (m_rx_tuser),
        .dest_qpn    (dest_qpn),
        .rx_pkt_done (rx_pkt_done)
    );

    tx_qpn_monitor u_tx_qpn_monitor (
        .clk         (clk),
        .rst         (rst),
        .s_tx_tdata  (s_tx_tdata),
        .s_tx_tkeep  (s_tx_tkeep),
        .s_tx_tvalid (s_tx_tvalid),
        .s_tx_tready (s_tx_tready),
        .s_tx_tlast  (s_tx_tlast),
        .s_tx_tuser  (s_tx_tuser),
        .m_tx_tdata  (m_tx_tdata),
        .m_tx_tkeep  (m_tx_tkeep),
        .m_tx_tvalid (m_tx_tvalid),
        .m_tx_tready (m_tx_tready),
        .m_tx_tlast  (m_tx_tlast),
        .m_tx_tuser  (m_tx_tuser),
        .local_qpn   (local_qpn),
        .tx_pkt_done (tx_pkt_done)
    );

    pkt_stats u_pkt_stats (
        .clk         (clk),
        .rst         (rst),
        .clear       (clear),
        .rx_pkt_done (rx_pkt_done),
        .tx_pkt_done (tx_pkt_done),
        .rx_pkts     (rx_pkts),
        .tx_pkts     (tx_pkts)
    );

    app_reg_file u_app_reg_file (
        .clk         (clk),
        .rst         (rst),
        .reg_wr_en   (reg_wr_en),
        .reg_wr_addr (reg_wr_addr),
        .reg_wr_data (reg_wr_data),
        .reg_wr_ack  (reg_wr_ack),
        .reg_rd_en   (reg_rd_en),
        .reg_rd_addr (reg_rd_addr),
        .reg_rd_data (reg_rd_data),
        .reg_rd_ack  (reg_rd_ack),
        .dest_qpn    (dest_qpn),
        .local_qpn   (local_qpn),
        .rx_pkts     (rx_pkts),
        .tx_pkts     (tx_pkts),
        .clear       (clear)
    );

endmodule

`default_nettype wire

/* hdl/app_reg_file.sv */
// app register file: clear flag write, status read mux and one-cycle acks
`timescale 1ns/1ps
`default_nettype none

`include "app_defs.svh"

module app_reg_file import app_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      reg_wr_en,
    input  reg_addr_t reg_wr_addr,
    input  reg_data_t reg_wr_data,
    output logic      reg_wr_ack,
    input  logic      reg_rd_en,
    input  reg_addr_t reg_rd_addr,
    output reg_data_t reg_rd_data,
    output logic      reg_rd_ack,
    input  qpn_t      dest_qpn,
    input  qpn_t      local_qpn,
    input  cnt_t      rx_pkts,
    input  cnt_t      tx_pkts,
    output logic      clear
);

    reg_data_t rd_word;

    // only the clear flag is writable, other addresses are acked and dropped
    always_ff @(posedge clk) begin
        if (rst) begin
            clear <= 1'b0;
        end else if (reg_wr_en && reg_wr_addr[7:0] == `APP_REG_CLEAR) begin
            clear <= reg_wr_data[0];
        end
    end

    // counters show zero for as long as clear is held
    always_comb begin
        case (reg_rd_addr[7:0])
            `APP_REG_DEST_QPN:  rd_word = reg_data_t'(dest_qpn);
            `APP_REG_RX_PKTS:   rd_word = clear ? '0 : rx_pkts;
            `APP_REG_TX_PKTS:   rd_word = clear ? '0 : tx_pkts;
            `APP_REG_VERSION:   rd_word = `APP_VERSION;
            `APP_REG_CLEAR:     rd_word = reg_data_t'(clear);
            `APP_REG_LOCAL_QPN: rd_word = reg_data_t'(local_qpn);
            default:            rd_word = '0;
        endcase
    end

    // read data, valid alongside reg_rd_ack
    always_ff @(posedge clk) begin
        if (reg_rd_en) begin
            reg_rd_data <= rd_word;
        end
    end

    // ack one cycle after each enable
    always_ff @(posedge clk) begin
        if (rst) begin
            reg_wr_ack <= 1'b0;
            reg_rd_ack <= 1'b0;
        end else begin
            reg_wr_ack <= reg_wr_en;
            reg_rd_ack <= reg_rd_en;
        end
    end

endmodule

`default_nettype wire

/* hdl/pkt_stats.sv */
// packet statistics: rx and tx completed-packet counters with hold-clear
`timescale 1ns/1ps
`default_nettype none

module pkt_stats import app_pkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic clear,
    input  logic rx_pkt_done,
    input  logic tx_pkt_done,
    output cnt_t rx_pkts,
    output cnt_t tx_pkts
);

    // clear wins over a done pulse in the same cycle
    always_ff @(posedge clk) begin
        if (rst || clear) begin
            rx_pkts <= '0;
        end else if (rx_pkt_done) begin
            rx_pkts <= rx_pkts + cnt_t'(1);
        end
    end

    // wraps at the top like the rx counter
    always_ff @(posedge clk) begin
        if (rst || clear) begin
            tx_pkts <= '0;
        end else if (tx_pkt_done) begin
            tx_pkts <= tx_pkts + cnt_t'(1);
        end
    end

endmodule

`default_nettype wire

/* hdl/tx_qpn_monitor.sv */
// tx qpn monitor: pass-through tx stream that latches the local qpn of first beats
`timescale 1ns/1ps
`default_nettype none

`include "app_defs.svh"

module tx_qpn_monitor import app_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  data_t    s_tx_tdata,
    input  keep_t    s_tx_tkeep,
    input  logic     s_tx_tvalid,
    output logic     s_tx_tready,
    input  logic     s_tx_tlast,
    input  tx_user_t s_tx_tuser,
    output data_t    m_tx_tdata,
    output keep_t    m_tx_tkeep,
    output logic     m_tx_tvalid,
    input  logic     m_tx_tready,
    output logic     m_tx_tlast,
    output tx_user_t m_tx_tuser,
    output qpn_t     local_qpn,
    output logic     tx_pkt_done
);

    pkt_pos_t pos;
    logic     xfer;
    logic     opcode_hit;

    assign xfer       = s_tx_tvalid && m_tx_tready;
    assign opcode_hit = s_tx_tdata[`APP_OPCODE_BIT +: `APP_OPCODE_W] == `APP_OPCODE_FIRST;

    always_ff @(posedge clk) begin
        if (rst) begin
            pos       <= PKT_FIRST;
            local_qpn <= '0;
        end else if (xfer) begin
            pos <= s_tx_tlast ? PKT_FIRST : PKT_BODY;
            // other opcodes keep the previous qpn
            if (pos == PKT_FIRST && opcode_hit) begin
                local_qpn <= s_tx_tdata[`APP_LOCAL_QPN_BIT +: `APP_QPN_W];
            end
        end
    end

    assign s_tx_tready = m_tx_tready;
    assign m_tx_tdata  = s_tx_tdata;
    assign m_tx_tkeep  = s_tx_tkeep;
    assign m_tx_tvalid = s_tx_tvalid;
    assign m_tx_tlast  = s_tx_tlast;
    assign m_tx_tuser  = s_tx_tuser;

    assign tx_pkt_done = xfer && s_tx_tlast;

endmodule

`default_nettype wire

/* hdl/rx_qpn_tagger.sv */
// rx qpn tagger: pass-through rx stream that tags tuser with the destination qpn
`timescale 1ns/1ps
`default_nettype none

`include "app_defs.svh"

module rx_qpn_tagger import app_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  data_t    s_rx_tdata,
    input  keep_t    s_rx_tkeep,
    input  logic     s_rx_tvalid,
    output logic     s_rx_tready,
    input  logic     s_rx_tlast,
    input  rx_user_t s_rx_tuser,
    output data_t    m_rx_tdata,
    output keep_t    m_rx_tkeep,
    output logic     m_rx_tvalid,
    input  logic     m_rx_tready,
    output logic     m_rx_tlast,
    output rx_user_t m_rx_tuser,
    output qpn_t     dest_qpn,
    output logic     rx_pkt_done
);

    pkt_pos_t pos;
    qpn_t     live_qpn;
    qpn_t     cur_qpn;
    logic     xfer;

    assign xfer     = s_rx_tvalid && m_rx_tready;
    assign live_qpn = s_rx_tdata[`APP_DEST_QPN_BIT +: `APP_QPN_W];

    // first beat carries the header, later beats reuse the latched value
    assign cur_qpn = (pos == PKT_FIRST) ? live_qpn : dest_qpn;

    always_ff @(posedge clk) begin
        if (rst) begin
            pos      <= PKT_FIRST;
            dest_qpn <= '0;
        end else if (xfer) begin
            pos <= s_rx_tlast ? PKT_FIRST : PKT_BODY;
            if (pos == PKT_FIRST) begin
                dest_qpn <= live_qpn;
            end
        end
    end

    assign s_rx_tready = m_rx_tready;
    assign m_rx_tdata  = s_rx_tdata;
    assign m_rx_tkeep  = s_rx_tkeep;
    assign m_rx_tvalid = s_rx_tvalid;
    assign m_rx_tlast  = s_rx_tlast;
    // qpn replaces the top 24 sideband bits
    assign m_rx_tuser  = {cur_qpn, s_rx_tuser[`APP_RX_USER_W-`APP_QPN_W-1:0]};

    assign rx_pkt_done = xfer && s_rx_tlast;

endmodule

`default_nettype wire

/* hdl/app_pkg.sv */
// app package: shared vector types and the packet position FSM encoding
`default_nettype none

`include "app_defs.svh"

package app_pkg;

    // stream beat fields
    typedef logic [`APP_DATA_W-1:0]     data_t;
    typedef logic [`APP_KEEP_W-1:0]     keep_t;
    typedef logic [`APP_RX_USER_W-1:0]  rx_user_t;
    typedef logic [`APP_TX_USER_W-1:0]  tx_user_t;

    // header and statistics values
    typedef logic [`APP_QPN_W-1:0]      qpn_t;
    typedef logic [`APP_CNT_W-1:0]      cnt_t;

    // register port
    typedef logic [`APP_REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [`APP_REG_DATA_W-1:0] reg_data_t;

    // where the next beat sits in its packet
    typedef enum logic {
        PKT_FIRST,
        PKT_BODY
    } pkt_pos_t;

endpackage

`default_nettype wire

/* hdl/app_defs.svh */
// app defines: widths, header bit offsets, opcode and register map of the packet app
`ifndef APP_DEFS_SVH
`define APP_DEFS_SVH

// stream widths
`define APP_DATA_W        512
`define APP_KEEP_W        64
`define APP_RX_USER_W     96
`define APP_TX_USER_W     17

// header fields
`define APP_QPN_W         24
`define APP_DEST_QPN_BIT  368
`define APP_LOCAL_QPN_BIT 464
`define APP_OPCODE_BIT    336
`define APP_OPCODE_W      5
`define APP_OPCODE_FIRST  5'b00110

// counters and register port
`define APP_CNT_W         32
`define APP_REG_ADDR_W    16
`define APP_REG_DATA_W    32
`define APP_VERSION       32'h20240105

// register offsets, decoded on address bits 7..0
`define APP_REG_DEST_QPN  8'h48
`define APP_REG_RX_PKTS   8'h4c
`define APP_REG_TX_PKTS   8'h50
`define APP_REG_VERSION   8'h60
`define APP_REG_CLEAR     8'h64
`define APP_REG_LOCAL_QPN 8'h94

`endif
